// ==== power_subsys.f ====
logic/pwr_pkg.sv
logic/pwr_ctrl_regs.sv
logic/domain_power_fsm.sv
logic/switch_ack_delay.sv
logic/power_subsys_top.sv
testbench/tb_power_subsys.sv

// ==== Makefile ====
# Verilator build and run of the power subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_power_subsys
FILELIST  ?= power_subsys.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Fails unless the pass line shows up in the simulator output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx 'Test OK'

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/tb_power_subsys.sv ====
// ******************************
// Power subsystem testbench
// Register bus sequences, power order monitor, random patterns
// ******************************

`timescale 1ns/1ps
`default_nettype none

module tb_power_subsys;

  localparam int NUM_DOMAINS        = 4;
  localparam int SWITCH_ACK_LATENCY = 15;
  localparam int RESET_CYCLES       = 16;
  localparam int RVALID_TIMEOUT     = 20;
  localparam int SETTLE_POLLS       = 100;
  localparam int BUSY_LSB           = 8;
  localparam logic [NUM_DOMAINS-1:0] ALL_DOMAINS = '1;

  logic        clk_i;
  logic        rst_n_i;
  logic        reg_req_i;
  logic        reg_we_i;
  logic [7:0]  reg_addr_i;
  logic [31:0] reg_wdata_i;
  logic        reg_rvalid_o;
  logic [31:0] reg_rdata_o;
  logic        reg_error_o;
  logic [NUM_DOMAINS-1:0] switch_n_o;
  logic [NUM_DOMAINS-1:0] iso_n_o;
  logic [NUM_DOMAINS-1:0] dom_rst_n_o;
  logic        intr_o;

  int          error_count;
  int          timeout_count;
  logic [31:0] lfsr_q;

  // Edge history of domain 0, in clock cycles
  int   cycle_cnt;
  int   iso_fall_cyc;
  int   iso_rise_cyc;
  int   rst_fall_cyc;
  int   rst_rise_cyc;
  int   sw_fall_cyc;
  int   sw_rise_cyc;
  logic iso_prev;
  logic rst_prev;
  logic sw_prev;

  power_subsys_top #(
    .NUM_DOMAINS       (NUM_DOMAINS),
    .SWITCH_ACK_LATENCY(SWITCH_ACK_LATENCY)
  ) power_subsys_top_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_req_i   (reg_req_i),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rvalid_o(reg_rvalid_o),
    .reg_rdata_o (reg_rdata_o),
    .reg_error_o (reg_error_o),
    .switch_n_o  (switch_n_o),
    .iso_n_o     (iso_n_o),
    .dom_rst_n_o (dom_rst_n_o),
    .intr_o      (intr_o)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    iso_prev  <= iso_n_o[0];
    rst_prev  <= dom_rst_n_o[0];
    sw_prev   <= switch_n_o[0];
    if (iso_prev && !iso_n_o[0]) iso_fall_cyc <= cycle_cnt;
    if (!iso_prev && iso_n_o[0]) iso_rise_cyc <= cycle_cnt;
    if (rst_prev && !dom_rst_n_o[0]) rst_fall_cyc <= cycle_cnt;
    if (!rst_prev && dom_rst_n_o[0]) rst_rise_cyc <= cycle_cnt;
    if (!sw_prev && switch_n_o[0]) sw_rise_cyc <= cycle_cnt;
    if (sw_prev && !switch_n_o[0]) sw_fall_cyc <= cycle_cnt;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
  endfunction

  // Once settled, off bits follow CTRL and nothing is busy
  function automatic logic [31:0] expected_status(input logic [NUM_DOMAINS-1:0] ctrl);
    logic [31:0] status;
    status = '0;
    status[NUM_DOMAINS-1:0] = ctrl;
    return status;
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = {value[30:0], lfsr_q[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH t=%0t %s got=0x%08h expected=0x%08h", $time, name, got, exp);
    end
  endtask

  // One strobe, then wait for the response
  task automatic bus_access(input logic we, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    @(posedge clk_i);
    #1;
    reg_req_i   = 1'b1;
    reg_we_i    = we;
    reg_addr_i  = addr;
    reg_wdata_i = wdata;
    @(posedge clk_i);
    #1;
    reg_req_i   = 1'b0;
    reg_we_i    = 1'b0;
    reg_wdata_i = '0;
    waited = 0;
    while (!reg_rvalid_o && waited < RVALID_TIMEOUT) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    rdata = reg_rdata_o;
    err   = reg_error_o;
    if (!reg_rvalid_o) begin
      timeout_count++;
      $display("Timeout: no bus response for address 0x%02h at t=%0t", addr, $time);
    end
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b1, addr, data, rdata, err);
    check_value("reg_error_o", 32'(err), 32'(exp_err));
    check_value("reg_rdata_o", rdata, '0);
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    bus_access(1'b0, addr, '0, data, err);
    check_value("reg_error_o", 32'(err), 32'd0);
  endtask

  task automatic wait_settled();
    logic [31:0] status;
    int          polls;
    polls = 0;
    reg_read(pwr_pkg::REG_STATUS, status);
    while (status[BUSY_LSB +: NUM_DOMAINS] != '0 && polls < SETTLE_POLLS) begin
      reg_read(pwr_pkg::REG_STATUS, status);
      polls++;
    end
    if (status[BUSY_LSB +: NUM_DOMAINS] != '0) begin
      timeout_count++;
      $display("Timeout: domains still busy at t=%0t", $time);
    end
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    logic [31:0] draw;
    logic [NUM_DOMAINS-1:0] ctrl;
    logic [NUM_DOMAINS-1:0] ctrl_n;
    logic [NUM_DOMAINS-1:0] prev_ctrl;

    error_count   = 0;
    timeout_count = 0;
    lfsr_q        = 32'hd5da;
    cycle_cnt     = 1;
    iso_fall_cyc  = 0;
    iso_rise_cyc  = 0;
    rst_fall_cyc  = 0;
    rst_rise_cyc  = 0;
    sw_fall_cyc   = 0;
    sw_rise_cyc   = 0;
    iso_prev      = 1'b1;
    rst_prev      = 1'b1;
    sw_prev       = 1'b0;
    rst_n_i       = 1'b0;
    reg_req_i     = 1'b0;
    reg_we_i      = 1'b0;
    reg_addr_i    = '0;
    reg_wdata_i   = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Reset values
    check_value("switch_n_o", 32'(switch_n_o), 32'd0);
    check_value("iso_n_o", 32'(iso_n_o), 32'(ALL_DOMAINS));
    check_value("dom_rst_n_o", 32'(dom_rst_n_o), 32'(ALL_DOMAINS));
    check_value("intr_o", 32'(intr_o), 32'd0);
    reg_read(pwr_pkg::REG_STATUS, rdata);
    check_value("REG_STATUS", rdata, '0);
    reg_read(pwr_pkg::REG_CTRL, rdata);
    check_value("REG_CTRL", rdata, '0);
    reg_read(pwr_pkg::REG_INTR, rdata);
    check_value("REG_INTR", rdata, '0);

    // Unmapped read and read-only write
    bus_access(1'b0, 8'h0c, '0, rdata, err);
    check_value("reg_error_o", 32'(err), 32'd1);
    check_value("reg_rdata_o", rdata, '0);
    reg_write(pwr_pkg::REG_STATUS, 32'hffff_ffff, 1'b1);
    reg_read(pwr_pkg::REG_CTRL, rdata);
    check_value("REG_CTRL", rdata, '0);

    // Power-down of domain 0
    reg_write(pwr_pkg::REG_CTRL, 32'h1, 1'b0);
    wait_settled();
    reg_read(pwr_pkg::REG_STATUS, rdata);
    check_value("REG_STATUS", rdata, expected_status(4'b0001));
    check_value("iso_n_o[0] fall seen", 32'(iso_fall_cyc != 0), 32'd1);
    check_value("iso_n_o[0] fall vs dom_rst_n_o[0] fall",
                32'(rst_fall_cyc != 0 && iso_fall_cyc <= rst_fall_cyc), 32'd1);
    check_value("iso_n_o[0] fall vs switch_n_o[0] rise",
                32'(sw_rise_cyc != 0 && iso_fall_cyc <= sw_rise_cyc), 32'd1);
    reg_read(pwr_pkg::REG_INTR, rdata);
    check_value("REG_INTR", rdata, 32'h1);
    check_value("intr_o", 32'(intr_o), 32'd1);
    reg_write(pwr_pkg::REG_INTR, 32'h1, 1'b0);
    check_value("intr_o", 32'(intr_o), 32'd0);
    reg_read(pwr_pkg::REG_INTR, rdata);
    check_value("REG_INTR", rdata, '0);

    // Power-up of domain 0
    reg_write(pwr_pkg::REG_CTRL, 32'h0, 1'b0);
    wait_settled();
    reg_read(pwr_pkg::REG_STATUS, rdata);
    check_value("REG_STATUS", rdata, expected_status('0));
    check_value("switch_n_o[0] fall vs dom_rst_n_o[0] rise",
                32'(sw_fall_cyc != 0 && sw_fall_cyc < rst_rise_cyc), 32'd1);
    check_value("dom_rst_n_o[0] rise vs iso_n_o[0] rise",
                32'(rst_rise_cyc != 0 && rst_rise_cyc <= iso_rise_cyc), 32'd1);
    reg_read(pwr_pkg::REG_INTR, rdata);
    check_value("REG_INTR", rdata, 32'h1);
    reg_write(pwr_pkg::REG_INTR, 32'(ALL_DOMAINS), 1'b0);

    // Random CTRL patterns
    prev_ctrl = '0;
    repeat (8) begin
      draw_bits(NUM_DOMAINS, draw);
      ctrl   = draw[NUM_DOMAINS-1:0];
      ctrl_n = ~ctrl;
      reg_write(pwr_pkg::REG_CTRL, 32'(ctrl), 1'b0);
      wait_settled();
      reg_read(pwr_pkg::REG_STATUS, rdata);
      check_value("REG_STATUS", rdata, expected_status(ctrl));
      check_value("switch_n_o", 32'(switch_n_o), 32'(ctrl));
      check_value("iso_n_o", 32'(iso_n_o), 32'(ctrl_n));
      check_value("dom_rst_n_o", 32'(dom_rst_n_o), 32'(ctrl_n));
      reg_read(pwr_pkg::REG_INTR, rdata);
      check_value("REG_INTR", rdata, 32'(ctrl ^ prev_ctrl));
      reg_write(pwr_pkg::REG_INTR, 32'(ALL_DOMAINS), 1'b0);
      prev_ctrl = ctrl;
    end

    $display("Run complete: %0d mismatches, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/power_subsys_top.sv ====
// ******************************
// Power subsystem top
// Registers, domain sequencers and switch cell model
// ******************************

`timescale 1ns/1ps
`default_nettype none

module power_subsys_top #(
  parameter int NUM_DOMAINS        = 4,
  parameter int SWITCH_ACK_LATENCY = 15
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       reg_req_i,
  input  logic                       reg_we_i,
  input  logic [pwr_pkg::ADDR_W-1:0] reg_addr_i,
  input  logic [pwr_pkg::DATA_W-1:0] reg_wdata_i,
  output logic                       reg_rvalid_o,
  output logic [pwr_pkg::DATA_W-1:0] reg_rdata_o,
  output logic                       reg_error_o,
  output logic [NUM_DOMAINS-1:0]     switch_n_o,
  output logic [NUM_DOMAINS-1:0]     iso_n_o,
  output logic [NUM_DOMAINS-1:0]     dom_rst_n_o,
  output logic                       intr_o
);

  logic [NUM_DOMAINS-1:0] off_req;
  logic [NUM_DOMAINS-1:0] is_off;
  logic [NUM_DOMAINS-1:0] busy;
  logic [NUM_DOMAINS-1:0] done;
  logic [NUM_DOMAINS-1:0] switch_ack_n;

  pwr_ctrl_regs #(
    .NUM_DOMAINS(NUM_DOMAINS)
  ) pwr_ctrl_regs_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_req_i   (reg_req_i),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .is_off_i    (is_off),
    .busy_i      (busy),
    .done_i      (done),
    .reg_rvalid_o(reg_rvalid_o),
    .reg_rdata_o (reg_rdata_o),
    .reg_error_o (reg_error_o),
    .off_req_o   (off_req),
    .intr_o      (intr_o)
  );

  // One sequencer per external domain
  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : gen_domain
    domain_power_fsm domain_power_fsm_i (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .off_req_i     (off_req[d]),
      .switch_ack_n_i(switch_ack_n[d]),
      .switch_n_o    (switch_n_o[d]),
      .iso_n_o       (iso_n_o[d]),
      .dom_rst_n_o   (dom_rst_n_o[d]),
      .is_off_o      (is_off[d]),
      .busy_o        (busy[d]),
      .done_o        (done[d])
    );
  end

  switch_ack_delay #(
    .NUM_DOMAINS       (NUM_DOMAINS),
    .SWITCH_ACK_LATENCY(SWITCH_ACK_LATENCY)
  ) switch_ack_delay_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .switch_n_i    (switch_n_o),
    .switch_ack_n_o(switch_ack_n)
  );

endmodule

`default_nettype wire

// ==== logic/switch_ack_delay.sv ====
// ******************************
// Switch cell model
// Delays each switch request into its acknowledge
// ******************************

`timescale 1ns/1ps
`default_nettype none

module switch_ack_delay #(
  parameter int NUM_DOMAINS        = 4,
  parameter int SWITCH_ACK_LATENCY = 15
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [NUM_DOMAINS-1:0] switch_n_i,
  output logic [NUM_DOMAINS-1:0] switch_ack_n_o
);

  logic [NUM_DOMAINS-1:0] stage_q [SWITCH_ACK_LATENCY];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // All cells start acknowledged on
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign switch_ack_n_o = stage_q[SWITCH_ACK_LATENCY-1];

endmodule

`default_nettype wire

// ==== logic/domain_power_fsm.sv ====
// ******************************
// Domain power sequencer
// Orders isolation, reset and switch for one domain
// ******************************

`timescale 1ns/1ps
`default_nettype none

module domain_power_fsm (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic off_req_i,
  input  logic switch_ack_n_i,
  output logic switch_n_o,
  output logic iso_n_o,
  output logic dom_rst_n_o,
  output logic is_off_o,
  output logic busy_o,
  output logic done_o
);

  pwr_pkg::pwr_state_e state_q;
  pwr_pkg::pwr_state_e state_d;

  logic switch_n_q;
  logic iso_n_q;
  logic dom_rst_n_q;
  logic is_off_q;
  logic busy_q;
  logic done_q;

  // Requests are only looked at in the two stable states
  always_comb begin
    state_d = state_q;
    case (state_q)
      pwr_pkg::ST_ON:         if (off_req_i) state_d = pwr_pkg::ST_ISOLATE;
      pwr_pkg::ST_ISOLATE:    state_d = pwr_pkg::ST_SWITCH_OFF;
      pwr_pkg::ST_SWITCH_OFF: if (switch_ack_n_i) state_d = pwr_pkg::ST_OFF;
      pwr_pkg::ST_OFF:        if (!off_req_i) state_d = pwr_pkg::ST_SWITCH_ON;
      pwr_pkg::ST_SWITCH_ON:  if (!switch_ack_n_i) state_d = pwr_pkg::ST_RELEASE;
      pwr_pkg::ST_RELEASE:    state_d = pwr_pkg::ST_ON;
      default:                state_d = pwr_pkg::ST_ON;
    endcase
  end

  // Outputs follow the state being entered
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= pwr_pkg::ST_ON;
      switch_n_q  <= 1'b0;
      iso_n_q     <= 1'b1;
      dom_rst_n_q <= 1'b1;
      is_off_q    <= 1'b0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      state_q     <= state_d;
      switch_n_q  <= (state_d == pwr_pkg::ST_SWITCH_OFF) || (state_d == pwr_pkg::ST_OFF);
      iso_n_q     <= (state_d == pwr_pkg::ST_ON);
      dom_rst_n_q <= (state_d == pwr_pkg::ST_ON) || (state_d == pwr_pkg::ST_ISOLATE) ||
                     (state_d == pwr_pkg::ST_RELEASE);
      is_off_q    <= (state_d == pwr_pkg::ST_OFF);
      busy_q      <= (state_d != pwr_pkg::ST_ON) && (state_d != pwr_pkg::ST_OFF);
      done_q      <= ((state_d == pwr_pkg::ST_OFF) && (state_q != pwr_pkg::ST_OFF)) ||
                     ((state_d == pwr_pkg::ST_ON) && (state_q == pwr_pkg::ST_RELEASE));
    end
  end

  assign switch_n_o  = switch_n_q;
  assign iso_n_o     = iso_n_q;
  assign dom_rst_n_o = dom_rst_n_q;
  assign is_off_o    = is_off_q;
  assign busy_o      = busy_q;
  assign done_o      = done_q;

endmodule

`default_nettype wire

// ==== logic/pwr_ctrl_regs.sv ====
// ******************************
// Power controller registers
// Decodes the host bus, holds control and sticky interrupt bits
// ******************************

`timescale 1ns/1ps
`default_nettype none

module pwr_ctrl_regs #(
  parameter int NUM_DOMAINS = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        reg_req_i,
  input  logic                        reg_we_i,
  input  logic [pwr_pkg::ADDR_W-1:0]  reg_addr_i,
  input  logic [pwr_pkg::DATA_W-1:0]  reg_wdata_i,
  input  logic [NUM_DOMAINS-1:0]      is_off_i,
  input  logic [NUM_DOMAINS-1:0]      busy_i,
  input  logic [NUM_DOMAINS-1:0]      done_i,
  output logic                        reg_rvalid_o,
  output logic [pwr_pkg::DATA_W-1:0]  reg_rdata_o,
  output logic                        reg_error_o,
  output logic [NUM_DOMAINS-1:0]      off_req_o,
  output logic                        intr_o
);

  logic                       hit_ctrl;
  logic                       hit_status;
  logic                       hit_intr;
  logic                       access_err;
  logic                       ctrl_we;
  logic [NUM_DOMAINS-1:0]     intr_clr;
  logic [NUM_DOMAINS-1:0]     intr_d;
  logic [pwr_pkg::DATA_W-1:0] status_word;
  logic [pwr_pkg::DATA_W-1:0] read_data;

  logic [NUM_DOMAINS-1:0]     ctrl_q;
  logic [NUM_DOMAINS-1:0]     intr_q;
  logic                       intr_out_q;
  logic                       rvalid_q;
  logic                       error_q;
  logic [pwr_pkg::DATA_W-1:0] rdata_q;

  always_comb begin
    hit_ctrl   = 1'b0;
    hit_status = 1'b0;
    hit_intr   = 1'b0;
    case (reg_addr_i)
      pwr_pkg::REG_CTRL:   hit_ctrl = 1'b1;
      pwr_pkg::REG_STATUS: hit_status = 1'b1;
      pwr_pkg::REG_INTR:   hit_intr = 1'b1;
      default: ;
    endcase
  end

  // Status is read-only, so a write there is treated as unmapped
  assign access_err = reg_we_i ? !(hit_ctrl || hit_intr)
                               : !(hit_ctrl || hit_status || hit_intr);

  assign ctrl_we  = reg_req_i && reg_we_i && hit_ctrl;
  assign intr_clr = (reg_req_i && reg_we_i && hit_intr) ?
                    reg_wdata_i[NUM_DOMAINS-1:0] : '0;

  // Set wins over a clear in the same cycle
  assign intr_d = (intr_q & ~intr_clr) | done_i;

  always_comb begin
    status_word = '0;
    status_word[NUM_DOMAINS-1:0] = is_off_i;
    status_word[pwr_pkg::MAX_DOMAINS +: NUM_DOMAINS] = busy_i;
  end

  always_comb begin
    read_data = '0;
    if (hit_ctrl) begin
      read_data[NUM_DOMAINS-1:0] = ctrl_q;
    end else if (hit_status) begin
      read_data = status_word;
    end else if (hit_intr) begin
      read_data[NUM_DOMAINS-1:0] = intr_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q     <= '0;
      intr_q     <= '0;
      intr_out_q <= 1'b0;
      rvalid_q   <= 1'b0;
      error_q    <= 1'b0;
    end else begin
      if (ctrl_we) begin
        ctrl_q <= reg_wdata_i[NUM_DOMAINS-1:0];
      end
      intr_q     <= intr_d;
      intr_out_q <= |intr_d;
      rvalid_q   <= reg_req_i;
      error_q    <= reg_req_i && access_err;
    end
  end

  // Writes and errors return zero data
  always_ff @(posedge clk_i) begin
    rdata_q <= (reg_req_i && !reg_we_i && !access_err) ? read_data : '0;
  end

  assign reg_rvalid_o = rvalid_q;
  assign reg_rdata_o  = rdata_q;
  assign reg_error_o  = error_q;
  assign off_req_o    = ctrl_q;
  assign intr_o       = intr_out_q;

endmodule

`default_nettype wire

// ==== logic/pwr_pkg.sv ====
// ******************************
// Power controller package
// Bus widths, register map and sequencer states
// ******************************

`default_nettype none

package pwr_pkg;

  // Register bus widths
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  // Busy bits in the status word start here
  localparam int MAX_DOMAINS = 8;

  // Register offsets
  typedef enum logic [ADDR_W-1:0] {
    REG_CTRL   = 8'h00,
    REG_STATUS = 8'h04,
    REG_INTR   = 8'h08
  } reg_addr_e;

  // Sequencer states for one external domain
  typedef enum logic [2:0] {
    ST_ON,
    ST_ISOLATE,
    ST_SWITCH_OFF,
    ST_OFF,
    ST_SWITCH_ON,
    ST_RELEASE
  } pwr_state_e;

endpackage

`default_nettype wire
